/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    parameter int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // Major opcodes kept in this core
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_jal   = 7'b1101111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        f3_beq = 3'b000,
        f3_bne = 3'b001,
        f3_blt = 3'b100,
        f3_bge = 3'b101
    } branch_funct3_e;

    typedef enum logic [2:0] {
        f3_add = 3'b000,   // Also addi and sub
        f3_slt = 3'b010,
        f3_xor = 3'b100,
        f3_or  = 3'b110,
        f3_and = 3'b111
    } arith_funct3_e;

    localparam logic [2:0] F3_WORD = 3'b010;  // lw and sw
    localparam int FUNCT7_ALT_BIT = 5;        // Selects sub over add

    // R-type field layout, other formats share opcode, rd, rs1 and funct3
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_fields_t;

    localparam word_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

endpackage

/* hdl/pipe_pkg.sv */
package pipe_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_xor,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_e;

    // All zero is a no-op
    typedef struct packed {
        alu_op_e        alu_op;
        logic           src_b_imm;
        logic           is_branch;
        branch_funct3_e br_funct3;
        logic           is_jal;
        logic           mem_read;
        logic           mem_write;
        logic           rd_valid;   // Only set for a nonzero rd
        wb_sel_e        wb_sel;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t    pc;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t    pc;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        ctrl_t    ctrl;
    } ex_mem_t;

    typedef struct packed {
        word_t    value;
        reg_idx_t rd;
        logic     rd_valid;
    } mem_wb_t;

    // One forwarding source for execute
    typedef struct packed {
        reg_idx_t rd;
        logic     rd_valid;
        logic     is_load;
        word_t    value;
    } fwd_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
    } imem_req_t;

endpackage

/* hdl/regfile.sv */
`timescale 1ns/1ns

module regfile (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_we,
    input  rv_isa_pkg::reg_idx_t i_waddr,
    input  rv_isa_pkg::word_t    i_wdata,
    input  rv_isa_pkg::reg_idx_t i_raddr_a,
    input  rv_isa_pkg::reg_idx_t i_raddr_b,
    output rv_isa_pkg::word_t    o_rdata_a,
    output rv_isa_pkg::word_t    o_rdata_b
);
    import rv_isa_pkg::*;

    word_t regs [1:31];  // x0 has no storage

    function automatic word_t read_port(reg_idx_t raddr);
        if (raddr == '0) begin
            return '0;
        end
        if (i_we && i_waddr == raddr) begin
            return i_wdata;  // Write-through
        end
        return regs[raddr];
    endfunction

    assign o_rdata_a = read_port(i_raddr_a);
    assign o_rdata_b = read_port(i_raddr_b);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Decode only marks rd valid for a nonzero index
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_we |-> i_waddr != '0
    );

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage #(
    parameter rv_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_stall,
    input  logic                i_flush,
    input  logic                i_redirect,
    input  rv_isa_pkg::word_t   i_target,
    output pipe_pkg::imem_req_t o_imem,
    input  rv_isa_pkg::word_t   i_imem_rdata,
    output pipe_pkg::if_id_t    o_if_id
);
    import rv_isa_pkg::*;

    word_t pc_q;

    // Fetch never idles, the PC is always the request
    assign o_imem = '{valid: 1'b1, addr: pc_q};

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc_q          <= RESET_PC;
            o_if_id.instr <= NOP_INSTR;
        end else if (!i_stall) begin
            pc_q       <= i_redirect ? i_target : pc_q + 32'd4;
            o_if_id.pc <= pc_q;
            if (i_flush) begin
                o_if_id.instr <= NOP_INSTR;  // Wrong-path fetch
            end else begin
                o_if_id.instr <= i_imem_rdata;
            end
        end
    end

    // Imem handshake, the address may not move before ready
    a_imem_addr_stable: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_imem.valid && i_stall |=> $stable(o_imem.addr)
    );

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_stall,
    input  logic              i_bubble,
    input  logic              i_flush,
    input  pipe_pkg::if_id_t  i_if_id,
    input  pipe_pkg::mem_wb_t i_wb,
    output pipe_pkg::id_ex_t  o_id_ex
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    instr_fields_t f;
    ctrl_t         ctrl;
    word_t         imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t         imm;
    word_t         rs1_val;
    word_t         rs2_val;
    reg_idx_t      raddr_a;
    reg_idx_t      raddr_b;

    assign f     = instr_fields_t'(i_if_id.instr);
    assign imm_i = {{20{f.funct7[6]}}, f.funct7, f.rs2};
    assign imm_s = {{20{f.funct7[6]}}, f.funct7, f.rd};
    assign imm_b = {{20{f.funct7[6]}}, f.rd[0], f.funct7[5:0], f.rd[4:1], 1'b0};
    assign imm_u = {i_if_id.instr[31:12], 12'b0};
    assign imm_j = {{12{f.funct7[6]}}, i_if_id.instr[19:12], f.rs2[0],
                    f.funct7[5:0], f.rs2[4:1], 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = imm_i;
        case (opcode_e'(f.opcode))
            op_lui: begin
                ctrl.alu_op    = alu_pass_b;
                ctrl.src_b_imm = 1'b1;
                ctrl.rd_valid  = 1'b1;
                imm            = imm_u;
            end
            op_jal: begin
                ctrl.is_jal   = 1'b1;
                ctrl.wb_sel   = wb_pc4;  // Link value
                ctrl.rd_valid = 1'b1;
                imm           = imm_j;
            end
            op_br: begin
                imm = imm_b;
                case (branch_funct3_e'(f.funct3))
                    f3_beq, f3_bne, f3_blt, f3_bge: begin
                        ctrl.is_branch = 1'b1;
                        ctrl.br_funct3 = branch_funct3_e'(f.funct3);
                    end
                    default: ;  // Unsigned compares not supported
                endcase
            end
            op_load: if (f.funct3 == F3_WORD) begin
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.wb_sel    = wb_mem;
                ctrl.rd_valid  = 1'b1;
            end
            op_store: if (f.funct3 == F3_WORD) begin
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_write = 1'b1;
                imm            = imm_s;
            end
            op_imm, op_reg: begin
                ctrl.src_b_imm = (f.opcode == op_imm);
                ctrl.rd_valid  = 1'b1;
                case (arith_funct3_e'(f.funct3))
                    f3_add: ctrl.alu_op = (f.opcode == op_reg && f.funct7[FUNCT7_ALT_BIT]) ?
                                          alu_sub : alu_add;
                    f3_slt: ctrl.alu_op = alu_slt;
                    f3_xor: ctrl.alu_op = alu_xor;
                    f3_or:  ctrl.alu_op = alu_or;
                    f3_and: ctrl.alu_op = alu_and;
                    default: ctrl = '0;  // Shifts and sltu
                endcase
            end
            default: ;
        endcase
        ctrl.rd_valid = ctrl.rd_valid && (f.rd != '0);
    end

    // During a bubble the held instruction reads its sources again
    assign raddr_a = i_bubble ? o_id_ex.rs1 : f.rs1;
    assign raddr_b = i_bubble ? o_id_ex.rs2 : f.rs2;

    regfile regfile_i (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_we      (i_wb.rd_valid),
        .i_waddr   (i_wb.rd),
        .i_wdata   (i_wb.value),
        .i_raddr_a (raddr_a),
        .i_raddr_b (raddr_b),
        .o_rdata_a (rs1_val),
        .o_rdata_b (rs2_val)
    );

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_id_ex.ctrl <= '0;
        end else if (!i_stall) begin
            if (i_flush) begin
                o_id_ex.ctrl <= '0;
            end else if (i_bubble) begin
                // Writeback may retire a source this cycle
                o_id_ex.rs1_val <= rs1_val;
                o_id_ex.rs2_val <= rs2_val;
            end else begin
                o_id_ex <= '{pc: i_if_id.pc, rs1_val: rs1_val, rs2_val: rs2_val,
                             imm: imm, rs1: f.rs1, rs2: f.rs2, rd: f.rd, ctrl: ctrl};
            end
        end
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_stall,
    input  logic               i_bubble,
    input  pipe_pkg::id_ex_t   i_id_ex,
    input  pipe_pkg::fwd_t     i_fwd_mem,
    input  pipe_pkg::fwd_t     i_fwd_wb,
    output logic               o_redirect,
    output rv_isa_pkg::word_t  o_target,
    output pipe_pkg::ex_mem_t  o_ex_mem
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t rs2_fwd;
    word_t alu_result;
    logic  br_taken;

    // Younger result wins
    function automatic word_t fwd_pick(reg_idx_t rs, word_t reg_val, fwd_t mem_src,
                                       fwd_t wb_src);
        if (mem_src.rd_valid && mem_src.rd != '0 && mem_src.rd == rs) begin
            return mem_src.value;
        end
        if (wb_src.rd_valid && wb_src.rd != '0 && wb_src.rd == rs) begin
            return wb_src.value;
        end
        return reg_val;
    endfunction

    assign op_a    = fwd_pick(i_id_ex.rs1, i_id_ex.rs1_val, i_fwd_mem, i_fwd_wb);
    assign rs2_fwd = fwd_pick(i_id_ex.rs2, i_id_ex.rs2_val, i_fwd_mem, i_fwd_wb);
    assign op_b    = i_id_ex.ctrl.src_b_imm ? i_id_ex.imm : rs2_fwd;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_slt:    alu_result = word_t'($signed(op_a) < $signed(op_b));
            alu_xor:    alu_result = op_a ^ op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_pass_b: alu_result = op_b;  // lui
            default:    alu_result = '0;
        endcase
    end

    // Branches compare the two registers, never the immediate
    always_comb begin
        case (i_id_ex.ctrl.br_funct3)
            f3_beq:  br_taken = (op_a == rs2_fwd);
            f3_bne:  br_taken = (op_a != rs2_fwd);
            f3_blt:  br_taken = ($signed(op_a) < $signed(rs2_fwd));
            f3_bge:  br_taken = ($signed(op_a) >= $signed(rs2_fwd));
            default: br_taken = 1'b0;
        endcase
    end

    assign o_redirect = i_id_ex.ctrl.is_jal || (i_id_ex.ctrl.is_branch && br_taken);
    assign o_target   = i_id_ex.pc + i_id_ex.imm;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_ex_mem.ctrl <= '0;
        end else if (!i_stall) begin
            if (i_bubble) begin
                o_ex_mem.ctrl <= '0;  // Load data not here yet, retry next cycle
            end else begin
                o_ex_mem <= '{pc: i_id_ex.pc, alu_result: alu_result, store_data: rs2_fwd,
                              rd: i_id_ex.rd, ctrl: i_id_ex.ctrl};
            end
        end
    end

endmodule

/* hdl/memory_stage.sv */
`timescale 1ns/1ns

module memory_stage (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_stall,
    input  pipe_pkg::ex_mem_t   i_ex_mem,
    output pipe_pkg::dmem_req_t o_dmem,
    input  logic                i_dmem_ready,
    input  rv_isa_pkg::word_t   i_dmem_rdata,
    output pipe_pkg::fwd_t      o_fwd_mem,
    output pipe_pkg::fwd_t      o_fwd_wb,
    output pipe_pkg::mem_wb_t   o_wb
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    word_t result;
    logic  wr_done_q;  // Store already taken while the pipe stood still

    assign o_dmem = '{
        valid: i_ex_mem.ctrl.mem_read || (i_ex_mem.ctrl.mem_write && !wr_done_q),
        write: i_ex_mem.ctrl.mem_write,
        addr:  {i_ex_mem.alu_result[31:2], 2'b00},
        wdata: i_ex_mem.store_data
    };

    // A held store is issued only once
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_done_q <= 1'b0;
        end else if (!i_stall) begin
            wr_done_q <= 1'b0;
        end else if (o_dmem.valid && o_dmem.write && i_dmem_ready) begin
            wr_done_q <= 1'b1;
        end
    end

    always_comb begin
        case (i_ex_mem.ctrl.wb_sel)
            wb_mem:  result = i_dmem_rdata;  // Valid whenever the pipe moves
            wb_pc4:  result = i_ex_mem.pc + 32'd4;
            default: result = i_ex_mem.alu_result;
        endcase
    end

    // is_load lets hazard control see a load-use pair
    assign o_fwd_mem = '{rd: i_ex_mem.rd, rd_valid: i_ex_mem.ctrl.rd_valid,
                         is_load: i_ex_mem.ctrl.mem_read, value: result};
    assign o_fwd_wb  = '{rd: o_wb.rd, rd_valid: o_wb.rd_valid, is_load: 1'b0,
                         value: o_wb.value};

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_wb.rd_valid <= 1'b0;
        end else if (!i_stall) begin
            o_wb <= '{value: result, rd: i_ex_mem.rd, rd_valid: i_ex_mem.ctrl.rd_valid};
        end
    end

    // Effective address of a word access must already be aligned
    a_dmem_aligned: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_dmem.valid |-> i_ex_mem.alu_result[1:0] == 2'b00
    );

endmodule

/* hdl/hazard_ctrl.sv */
`timescale 1ns/1ns

module hazard_ctrl (
    input  logic             i_imem_valid,
    input  logic             i_imem_ready,
    input  logic             i_dmem_valid,
    input  logic             i_dmem_ready,
    input  pipe_pkg::fwd_t   i_fwd_mem,
    input  pipe_pkg::id_ex_t i_id_ex,
    input  logic             i_redirect,
    output logic             o_stall_all,
    output logic             o_bubble_ex,
    output logic             o_flush_front
);
    logic mem_stall;
    logic load_use;

    assign mem_stall = (i_imem_valid && !i_imem_ready) || (i_dmem_valid && !i_dmem_ready);

    // Load in memory feeding the instruction in execute
    assign load_use = i_fwd_mem.is_load && i_fwd_mem.rd_valid && i_fwd_mem.rd != '0 &&
                      (i_fwd_mem.rd == i_id_ex.rs1 || i_fwd_mem.rd == i_id_ex.rs2);

    assign o_stall_all   = mem_stall;
    assign o_bubble_ex   = load_use && !mem_stall;
    // Redirect from a retried instruction is not trusted
    assign o_flush_front = i_redirect && !mem_stall && !load_use;

endmodule

/* hdl/rv_pipeline_top.sv */
`timescale 1ns/1ns

module rv_pipeline_top #(
    parameter rv_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                i_rst_n,
    output pipe_pkg::imem_req_t o_imem,
    input  logic                i_imem_ready,
    input  rv_isa_pkg::word_t   i_imem_rdata,
    output pipe_pkg::dmem_req_t o_dmem,
    input  logic                i_dmem_ready,
    input  rv_isa_pkg::word_t   i_dmem_rdata
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    fwd_t    fwd_mem;
    fwd_t    fwd_wb;
    logic    redirect;
    word_t   target;
    logic    stall_all;
    logic    bubble_ex;
    logic    flush_front;

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_stall      (stall_all || bubble_ex),  // Front end holds during a bubble
        .i_flush      (flush_front),
        .i_redirect   (redirect),
        .i_target     (target),
        .o_imem       (o_imem),
        .i_imem_rdata (i_imem_rdata),
        .o_if_id      (if_id)
    );

    decode_stage decode_i (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_stall  (stall_all),
        .i_bubble (bubble_ex),
        .i_flush  (flush_front),
        .i_if_id  (if_id),
        .i_wb     (mem_wb),
        .o_id_ex  (id_ex)
    );

    execute_stage execute_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (stall_all),
        .i_bubble   (bubble_ex),
        .i_id_ex    (id_ex),
        .i_fwd_mem  (fwd_mem),
        .i_fwd_wb   (fwd_wb),
        .o_redirect (redirect),
        .o_target   (target),
        .o_ex_mem   (ex_mem)
    );

    memory_stage memory_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_stall      (stall_all),
        .i_ex_mem     (ex_mem),
        .o_dmem       (o_dmem),
        .i_dmem_ready (i_dmem_ready),
        .i_dmem_rdata (i_dmem_rdata),
        .o_fwd_mem    (fwd_mem),
        .o_fwd_wb     (fwd_wb),
        .o_wb         (mem_wb)
    );

    hazard_ctrl hazard_i (
        .i_imem_valid  (o_imem.valid),
        .i_imem_ready  (i_imem_ready),
        .i_dmem_valid  (o_dmem.valid),
        .i_dmem_ready  (i_dmem_ready),
        .i_fwd_mem     (fwd_mem),
        .i_id_ex       (id_ex),
        .i_redirect    (redirect),
        .o_stall_all   (stall_all),
        .o_bubble_ex   (bubble_ex),
        .o_flush_front (flush_front)
    );

endmodule

/* include/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Instruction-set model of the program in imem, fills expected_q with its stores
// and returns the number of instructions executed up to the jal-to-self loop
function automatic int reference_run();
    word_t      regs [32];
    word_t      dm [DMEM_WORDS];
    word_t      pc;
    word_t      nxt;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      ea;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    logic [6:0] op;
    logic [2:0] f3;
    logic [4:0] rd;
    logic       taken;
    int         steps;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++) dm[i] = dmem_init[i];
    expected_q.delete();
    pc    = RESET_PC;
    steps = 0;
    while (steps < MAX_STEPS) begin
        ins = fetch_word(pc);
        steps++;
        if (ins == JAL_SELF) break;
        op    = ins[6:0];
        rd    = ins[11:7];
        f3    = ins[14:12];
        a     = regs[ins[19:15]];
        b     = regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = pc + 32'd4;
        case (op)
            7'b0110111: regs[rd] = {ins[31:12], 12'b0};
            7'b1101111: begin
                regs[rd] = pc + 32'd4;
                nxt      = pc + imm_j;
            end
            7'b1100011: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    default: taken = 1'b0;
                endcase
                if (taken) nxt = pc + imm_b;
            end
            7'b0000011: if (f3 == 3'b010) begin
                ea       = a + imm_i;
                regs[rd] = dm[ea[7:2]];
            end
            7'b0100011: if (f3 == 3'b010) begin
                ea = a + imm_s;
                expected_q.push_back('{valid: 1'b1, write: 1'b1, addr: ea, wdata: b});
                dm[ea[7:2]] = b;
            end
            7'b0010011, 7'b0110011: begin
                if (op == 7'b0010011) b = imm_i;
                case (f3)
                    3'b000: regs[rd] = (op == 7'b0110011 && ins[30]) ? a - b : a + b;
                    3'b010: regs[rd] = word_t'($signed(a) < $signed(b));
                    3'b100: regs[rd] = a ^ b;
                    3'b110: regs[rd] = a | b;
                    3'b111: regs[rd] = a & b;
                    default: ;
                endcase
            end
            default: ;
        endcase
        regs[0] = '0;
        pc      = nxt;
    end
    return steps;
endfunction

`endif

/* testbench/tb_rv_pipeline.sv */
`timescale 1ns/1ns

module tb_rv_pipeline;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam word_t RESET_PC   = 32'h0000_0100;
    localparam int    CLK_PERIOD = 20;
    localparam int    IMEM_WORDS = 64;
    localparam int    DMEM_WORDS = 64;
    localparam int    MAX_STEPS  = 2000;
    localparam word_t JAL_SELF   = 32'h0000_006f;  // jal x0, 0

    logic      clk = 1'b0;
    logic      i_rst_n;
    imem_req_t o_imem;
    logic      i_imem_ready;
    word_t     i_imem_rdata;
    dmem_req_t o_dmem;
    logic      i_dmem_ready;
    word_t     i_dmem_rdata;

    word_t     imem [IMEM_WORDS];
    word_t     dmem [DMEM_WORDS];
    word_t     dmem_init [DMEM_WORDS];
    dmem_req_t expected_q [$];
    int        prog_len;
    int        seed;
    logic      bp_en;
    int        got;
    int        errors;
    int        checks;
    int        tests;
    int        failed_tests;
    time       deadline;
    string     cur_test;

    function automatic word_t fetch_word(word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        return (idx < IMEM_WORDS) ? imem[idx] : NOP_INSTR;
    endfunction

    `include "tb_ref_model.svh"

    rv_pipeline_top #(.RESET_PC(RESET_PC)) dut_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .o_imem       (o_imem),
        .i_imem_ready (i_imem_ready),
        .i_imem_rdata (i_imem_rdata),
        .o_dmem       (o_dmem),
        .i_dmem_ready (i_dmem_ready),
        .i_dmem_rdata (i_dmem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Memory models answer 2 ns after the edge
    always @(posedge clk) begin
        #2;
        i_imem_ready = bp_en ? (($random(seed) & 32'sd3) != 0) : 1'b1;
        i_dmem_ready = bp_en ? (($random(seed) & 32'sd3) != 0) : 1'b1;
        i_imem_rdata = fetch_word(o_imem.addr);
        i_dmem_rdata = dmem[o_dmem.addr[7:2]];
    end

    // Accepted writes sampled at mid-cycle
    always @(negedge clk) begin
        if (i_rst_n && o_dmem.valid && o_dmem.write && i_dmem_ready) begin
            dmem[o_dmem.addr[7:2]] = o_dmem.wdata;
            if (expected_q.size() == 0) begin
                errors++;
                $display("Unexpected store to %h at %0t ns in %s", o_dmem.addr, $time, cur_test);
            end else begin
                check_store(o_dmem, expected_q.pop_front());
            end
            got++;
        end
    end

    initial begin
        while ($time <= deadline) @(posedge clk);
        $display("Timeout in %s after %0t ns, stores seen %0d", cur_test, $time, got);
        $display("Errors found");
        $finish;
    end

    task automatic check_word(input string name, input word_t actual, input word_t exp);
        checks++;
        if (actual !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, actual, exp);
        end
    endtask

    task automatic check_store(input dmem_req_t actual, input dmem_req_t exp);
        checks++;
        if (actual !== exp) begin
            errors++;
            $display("[FAIL] %0t ns o_dmem: got v%b w%b %h=%h, expected v%b w%b %h=%h",
                     $time, actual.valid, actual.write, actual.addr, actual.wdata,
                     exp.valid, exp.write, exp.addr, exp.wdata);
        end
    endtask

    function automatic word_t r_type(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [6:0] op, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                     logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t j_type(reg_idx_t rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic append_instr(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program(input int which);
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = NOP_INSTR;
        prog_len = 0;
        case (which)
            2: begin  // Dependent ALU chain
                append_instr(u_type(1, 20'h12345));
                append_instr(i_type(op_imm, 3'b000, 2, 1, 12'h678));
                append_instr(r_type(7'h00, 3'b000, 3, 2, 1));
                append_instr(r_type(7'h20, 3'b000, 4, 3, 2));
                append_instr(i_type(op_imm, 3'b100, 5, 4, 12'hfff));
                append_instr(r_type(7'h00, 3'b010, 6, 5, 4));
                append_instr(i_type(op_imm, 3'b010, 7, 5, 12'h005));
                append_instr(r_type(7'h00, 3'b110, 8, 6, 7));
                append_instr(r_type(7'h00, 3'b111, 9, 3, 5));
                append_instr(i_type(op_imm, 3'b110, 10, 9, 12'h0f0));
                append_instr(i_type(op_imm, 3'b111, 11, 10, 12'h7ff));
                append_instr(r_type(7'h00, 3'b100, 12, 11, 3));
                append_instr(s_type(12, 0, 12'd24));
                append_instr(s_type(3, 0, 12'd0));
                append_instr(s_type(4, 0, 12'd4));
                append_instr(s_type(5, 0, 12'd8));
                append_instr(s_type(6, 0, 12'd12));
                append_instr(s_type(7, 0, 12'd16));
                append_instr(s_type(8, 0, 12'd20));
            end
            3: begin  // Loads with an immediate user
                append_instr(i_type(op_load, 3'b010, 1, 0, 12'd8));
                append_instr(r_type(7'h00, 3'b000, 2, 1, 1));
                append_instr(i_type(op_load, 3'b010, 3, 0, 12'd12));
                append_instr(i_type(op_imm, 3'b000, 4, 3, 12'd1));
                append_instr(r_type(7'h00, 3'b000, 5, 2, 4));
                append_instr(s_type(5, 0, 12'd32));
                append_instr(i_type(op_load, 3'b010, 6, 0, 12'd32));
                append_instr(s_type(6, 0, 12'd36));
            end
            default: begin  // Branches and jal with stores in the wrong-path slots
                append_instr(i_type(op_imm, 3'b000, 1, 0, 12'd5));
                append_instr(i_type(op_imm, 3'b000, 2, 0, 12'hffd));
                append_instr(b_type(3'b000, 1, 1, 13'd12));
                append_instr(s_type(1, 0, 12'd40));
                append_instr(s_type(2, 0, 12'd44));
                append_instr(b_type(3'b001, 1, 1, 13'd8));
                append_instr(s_type(1, 0, 12'd48));
                append_instr(b_type(3'b100, 2, 1, 13'd12));
                append_instr(s_type(1, 0, 12'd52));
                append_instr(s_type(2, 0, 12'd56));
                append_instr(b_type(3'b101, 2, 1, 13'd8));
                append_instr(s_type(2, 0, 12'd60));
                append_instr(b_type(3'b001, 1, 2, 13'd12));
                append_instr(s_type(1, 0, 12'd64));
                append_instr(s_type(1, 0, 12'd68));
                append_instr(j_type(5, 21'd12));
                append_instr(s_type(1, 0, 12'd72));
                append_instr(s_type(1, 0, 12'd76));
                append_instr(s_type(5, 0, 12'd80));   // Link value
                append_instr(b_type(3'b101, 1, 2, 13'd8));
                append_instr(s_type(1, 0, 12'd84));
                append_instr(b_type(3'b000, 1, 2, 13'd8));
                append_instr(s_type(2, 0, 12'd88));
            end
        endcase
        append_instr(JAL_SELF);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2 i_rst_n = 1'b0;
        for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = dmem_init[i];
        repeat (4) @(posedge clk);
        #2 i_rst_n = 1'b1;
    endtask

    task automatic report_test(input int errs_before);
        tests++;
        if (errors != errs_before) failed_tests++;
        $display("Test %-26s %s", cur_test, (errors == errs_before) ? "passed" : "FAILED");
    endtask

    task automatic run_reset_test();
        int errs_before;
        errs_before = errors;
        cur_test    = "reset state";
        build_program(2);
        apply_reset();
        check_word("o_imem.addr", o_imem.addr, RESET_PC);
        check_word("o_imem.valid", word_t'(o_imem.valid), 32'd1);
        check_word("o_dmem.valid", word_t'(o_dmem.valid), '0);
        report_test(errs_before);
    endtask

    task automatic run_program_test(input int which, input logic back_pressure);
        int errs_before;
        int steps;
        int exp_total;
        errs_before = errors;
        cur_test    = $sformatf("%s%s", (which == 2) ? "alu chain" :
                                (which == 3) ? "load use" : "branches",
                                back_pressure ? " with back-pressure" : "");
        build_program(which);
        steps     = reference_run();
        exp_total = expected_q.size();
        bp_en     = back_pressure;
        apply_reset();
        got = 0;
        check_word("o_imem.addr", o_imem.addr, RESET_PC);
        deadline = $time + time'(steps * 40 * CLK_PERIOD);
        while (got < exp_total) @(negedge clk);
        repeat (10) @(posedge clk);  // Catch late or extra stores
        report_test(errs_before);
    endtask

    initial begin
        seed         = 32'h646b;
        i_rst_n      = 1'b0;
        i_imem_ready = 1'b1;
        i_dmem_ready = 1'b1;
        i_imem_rdata = NOP_INSTR;
        i_dmem_rdata = '0;
        bp_en        = 1'b0;
        deadline     = 200 * CLK_PERIOD;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        cur_test     = "startup";
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem_init[i] = (word_t'(i * 4) * 32'h9e37_79b1) ^ 32'hc0de_5a00;
        end
        run_reset_test();
        for (int pass = 0; pass < 2; pass++) begin
            for (int t = 2; t <= 4; t++) run_program_test(t, pass == 1);
        end
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hdl/rv_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/regfile.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_ctrl.sv
hdl/rv_pipeline_top.sv
testbench/tb_rv_pipeline.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the pipeline testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_rv_pipeline \
    -Mdir obj_dir -o sim_tb_rv_pipeline
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_rv_pipeline > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
